// File: project.f
+incdir+hdl
hdl/isaPkg.sv
hdl/pipePkg.sv
hdl/stageLink.sv
hdl/fetchStage.sv
hdl/decodeStage.sv
hdl/executeStage.sv
hdl/memoryStage.sv
hdl/hazardUnit.sv
hdl/mipsCore.sv
dv/mipsCore_properties.sv
dv/mipsCore_tb.sv

// File: run.sh
#!/bin/sh
# Build the MIPS pipeline testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f project.f \
	--top-module mipsCore_tb -o simv &&
	./obj_dir/simv | tee /dev/stderr | grep -qx "Test passed" &&
	echo "simulation ok" ||
	{ echo "simulation did not pass"; exit 1; }

// File: dv/mipsCore_tb.sv
`timescale 1ns/100ps
`include "mips_params.svh"
`default_nettype none

module mipsCore_tb;

	localparam int RESET_CYCLES = 16;
	localparam int TAIL_CYCLES  = 10;
	localparam int NGROUPS      = 6;

	// MIPS32 opcode and function field values
	localparam logic [5:0] OP_SPECIAL = 6'h00;
	localparam logic [5:0] OP_JAL     = 6'h03;
	localparam logic [5:0] OP_BEQ     = 6'h04;
	localparam logic [5:0] OP_ORI     = 6'h0D;
	localparam logic [5:0] OP_LUI     = 6'h0F;
	localparam logic [5:0] OP_LW      = 6'h23;
	localparam logic [5:0] OP_SW      = 6'h2B;
	localparam logic [5:0] FN_JR      = 6'h08;
	localparam logic [5:0] FN_ADDU    = 6'h21;
	localparam logic [5:0] FN_SUBU    = 6'h23;

	typedef struct packed {
		logic [3:0]  grp;
		logic [31:0] pc;
		logic [4:0]  rd;
		logic [31:0] val;
	} retireT;

	typedef struct packed {
		logic [3:0]  grp;
		logic [31:0] addr;
		logic [31:0] data;
	} storeT;

	logic                            clk;
	logic                            arstN;
	logic [`MIPS_XLEN-1:0]           imemAddr;
	logic [`MIPS_XLEN-1:0]           imemData;
	logic                            wbEn;
	logic [$clog2(`MIPS_NREGS)-1:0] wbReg;
	logic [`MIPS_XLEN-1:0]           wbData;
	logic [`MIPS_XLEN-1:0]           wbPc;
	logic                            memWrEn;
	logic [`MIPS_XLEN-1:0]           memAddr;
	logic [`MIPS_XLEN-1:0]           memWrData;

	logic [31:0] progWords [$];
	retireT      retireTab [$];
	storeT       storeTab [$];
	string       groupName [1:NGROUPS];
	int          groupLeft [1:NGROUPS];
	int          groupErrors [1:NGROUPS];
	int          retireIdx;
	int          storeIdx;
	int          checks;
	int          errors;

	mipsCore dut (.clk(clk), .arstN(arstN), .imemAddr(imemAddr), .imemData(imemData),
		.wbEn(wbEn), .wbReg(wbReg), .wbData(wbData), .wbPc(wbPc), .memWrEn(memWrEn),
		.memAddr(memAddr), .memWrData(memWrData));

	bind mipsCore mipsCore_properties uProps (.clk(clk), .arstN(arstN), .imemAddr(imemAddr),
		.wbEn(wbEn), .wbReg(wbReg), .wbData(wbData), .wbPc(wbPc), .memWrEn(memWrEn),
		.memAddr(memAddr), .memWrData(memWrData));

	initial begin
		clk = 1'b0;
		forever begin
			#10 clk = ~clk;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Instruction encoding and program

	function automatic logic [31:0] rFormat(input logic [5:0] funct, input logic [4:0] rd,
			input logic [4:0] rs, input logic [4:0] rt);
		return {OP_SPECIAL, rs, rt, rd, 5'd0, funct};
	endfunction

	function automatic logic [31:0] iFormat(input logic [5:0] op, input logic [4:0] rt,
			input logic [4:0] rs, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] pcOf(input int idx);
		return `MIPS_RESET_PC + 32'(idx * 4);
	endfunction

	// Offset counts words from the delay slot
	function automatic logic [15:0] branchOff(input int from, input int to);
		return 16'(to - from - 1);
	endfunction

	function automatic logic [31:0] fetchWord(input logic [31:0] addr);
		int idx;
		idx = int'((addr - `MIPS_RESET_PC) >> 2);
		if (addr < `MIPS_RESET_PC || idx >= progWords.size()) begin
			return 32'h0;
		end
		return progWords[idx];
	endfunction

	task automatic loadProgram();
		progWords.push_back(iFormat(OP_LUI, 5'd1, 5'd0, 16'h1234));
		progWords.push_back(iFormat(OP_ORI, 5'd1, 5'd1, 16'h5678));
		progWords.push_back(rFormat(FN_ADDU, 5'd2, 5'd1, 5'd1));
		progWords.push_back(rFormat(FN_SUBU, 5'd3, 5'd2, 5'd1));
		progWords.push_back(iFormat(OP_ORI, 5'd4, 5'd0, 16'h0011));
		progWords.push_back(rFormat(FN_ADDU, 5'd5, 5'd4, 5'd1));
		progWords.push_back(rFormat(FN_ADDU, 5'd6, 5'd3, 5'd5));
		// Store then load through r7 = 0x100
		progWords.push_back(iFormat(OP_ORI, 5'd7, 5'd0, 16'h0100));
		progWords.push_back(iFormat(OP_SW, 5'd6, 5'd7, 16'h0000));
		progWords.push_back(iFormat(OP_LW, 5'd8, 5'd7, 16'h0000));
		progWords.push_back(iFormat(OP_ORI, 5'd9, 5'd0, 16'h00AB));
		progWords.push_back(iFormat(OP_SW, 5'd9, 5'd7, 16'h0004));
		// Load-use pairs
		progWords.push_back(iFormat(OP_LW, 5'd10, 5'd7, 16'h0004));
		progWords.push_back(rFormat(FN_ADDU, 5'd11, 5'd10, 5'd8));
		progWords.push_back(rFormat(FN_SUBU, 5'd12, 5'd11, 5'd10));
		progWords.push_back(iFormat(OP_LW, 5'd13, 5'd7, 16'h0000));
		progWords.push_back(iFormat(OP_SW, 5'd13, 5'd7, 16'h0008));
		// Not taken beq at 18, taken beq at 22 skipping 24 and 25
		progWords.push_back(iFormat(OP_ORI, 5'd14, 5'd0, 16'h0005));
		progWords.push_back(iFormat(OP_BEQ, 5'd4, 5'd14, branchOff(18, 24)));
		progWords.push_back(iFormat(OP_ORI, 5'd15, 5'd0, 16'h0001));
		progWords.push_back(iFormat(OP_ORI, 5'd16, 5'd0, 16'h0002));
		progWords.push_back(iFormat(OP_LW, 5'd17, 5'd7, 16'h0004));
		progWords.push_back(iFormat(OP_BEQ, 5'd10, 5'd17, branchOff(22, 26)));
		progWords.push_back(iFormat(OP_ORI, 5'd18, 5'd0, 16'h0003));
		progWords.push_back(iFormat(OP_ORI, 5'd19, 5'd0, 16'h0BAD));
		progWords.push_back(iFormat(OP_ORI, 5'd20, 5'd0, 16'h0BAD));
		progWords.push_back(iFormat(OP_ORI, 5'd21, 5'd0, 16'h0004));
		// Call to 32, return lands on 29, then branch over the routine to 36
		progWords.push_back({OP_JAL, 26'(pcOf(32) >> 2)});
		progWords.push_back(iFormat(OP_ORI, 5'd22, 5'd0, 16'h0007));
		progWords.push_back(iFormat(OP_ORI, 5'd23, 5'd0, 16'h0009));
		progWords.push_back(iFormat(OP_BEQ, 5'd0, 5'd0, branchOff(30, 36)));
		progWords.push_back(32'h0);
		progWords.push_back(rFormat(FN_ADDU, 5'd24, 5'd31, 5'd0));
		progWords.push_back(rFormat(FN_ADDU, 5'd26, 5'd31, 5'd0));
		progWords.push_back(rFormat(FN_JR, 5'd0, 5'd26, 5'd0));
		progWords.push_back(iFormat(OP_ORI, 5'd27, 5'd0, 16'h000C));
		// Register zero
		progWords.push_back(iFormat(OP_ORI, 5'd0, 5'd0, 16'h0055));
		progWords.push_back(rFormat(FN_ADDU, 5'd28, 5'd0, 5'd0));
		progWords.push_back(rFormat(FN_ADDU, 5'd29, 5'd1, 5'd0));
	endtask

	//////////////////////////////////////////////////////////////////////
	// Expected retirements and stores, in program execution order

	task automatic retireEntry(input int grp, input int idx, input int rd, input logic [31:0] v);
		retireTab.push_back(retireT'{grp: 4'(grp), pc: pcOf(idx), rd: 5'(rd), val: v});
	endtask

	task automatic storeEntry(input int grp, input logic [31:0] a, input logic [31:0] d);
		storeTab.push_back(storeT'{grp: 4'(grp), addr: a, data: d});
	endtask

	task automatic loadExpected();
		retireEntry(1, 0, 1, 32'h1234_0000);
		retireEntry(1, 1, 1, 32'h1234_5678);
		retireEntry(1, 2, 2, 32'h2468_ACF0);
		retireEntry(1, 3, 3, 32'h1234_5678);
		retireEntry(1, 4, 4, 32'h0000_0011);
		retireEntry(1, 5, 5, 32'h1234_5689);
		retireEntry(1, 6, 6, 32'h2468_AD01);
		retireEntry(2, 7, 7, 32'h0000_0100);
		retireEntry(2, 9, 8, 32'h2468_AD01);
		retireEntry(2, 10, 9, 32'h0000_00AB);
		storeEntry(2, 32'h0000_0100, 32'h2468_AD01);
		storeEntry(2, 32'h0000_0104, 32'h0000_00AB);
		retireEntry(3, 12, 10, 32'h0000_00AB);
		retireEntry(3, 13, 11, 32'h2468_ADAC);
		retireEntry(3, 14, 12, 32'h2468_AD01);
		retireEntry(3, 15, 13, 32'h2468_AD01);
		storeEntry(3, 32'h0000_0108, 32'h2468_AD01);
		retireEntry(4, 17, 14, 32'h0000_0005);
		retireEntry(4, 19, 15, 32'h0000_0001);
		retireEntry(4, 20, 16, 32'h0000_0002);
		retireEntry(4, 21, 17, 32'h0000_00AB);
		retireEntry(4, 23, 18, 32'h0000_0003);
		retireEntry(4, 26, 21, 32'h0000_0004);
		retireEntry(5, 27, 31, pcOf(29));
		retireEntry(5, 28, 22, 32'h0000_0007);
		retireEntry(5, 32, 24, pcOf(29));
		retireEntry(5, 33, 26, pcOf(29));
		retireEntry(5, 35, 27, 32'h0000_000C);
		retireEntry(5, 29, 23, 32'h0000_0009);
		retireEntry(6, 37, 28, 32'h0000_0000);
		retireEntry(6, 38, 29, 32'h1234_5678);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Checking

	task automatic flagError(input int grp, input string msg);
		errors++;
		groupErrors[grp]++;
		$display("[ERROR] %0t ns: %s", $time, msg);
	endtask

	task automatic groupMatched(input int grp);
		groupLeft[grp]--;
		if (groupLeft[grp] == 0) begin
			$display("group %0d (%s) finished with %0d errors", grp, groupName[grp],
				groupErrors[grp]);
		end
	endtask

	task automatic compareCycle();
		retireT r;
		storeT  s;
		if (wbEn) begin
			if (retireIdx >= retireTab.size()) begin
				errors++;
				$display("Unexpected extra retirement of r%0d from pc %h", wbReg, wbPc);
			end else begin
				r = retireTab[retireIdx];
				checks++;
				if (wbPc !== r.pc) begin
					flagError(r.grp, $sformatf("retirement %0d pc %h, expected %h",
						retireIdx, wbPc, r.pc));
				end
				if (wbReg !== r.rd) begin
					flagError(r.grp, $sformatf("retirement %0d register %0d, expected %0d",
						retireIdx, wbReg, r.rd));
				end
				if (wbData !== r.val) begin
					flagError(r.grp, $sformatf("retirement %0d data %h, expected %h",
						retireIdx, wbData, r.val));
				end
				retireIdx++;
				groupMatched(r.grp);
			end
		end
		if (memWrEn) begin
			if (storeIdx >= storeTab.size()) begin
				errors++;
				$display("Unexpected extra store to %h", memAddr);
			end else begin
				s = storeTab[storeIdx];
				checks++;
				if (memAddr !== s.addr) begin
					flagError(s.grp, $sformatf("store %0d address %h, expected %h",
						storeIdx, memAddr, s.addr));
				end
				if (memWrData !== s.data) begin
					flagError(s.grp, $sformatf("store %0d data %h, expected %h",
						storeIdx, memWrData, s.data));
				end
				storeIdx++;
				groupMatched(s.grp);
			end
		end
	endtask

	task automatic reportMissing(input int limit);
		$display("Run stopped after %0d cycles and these entries never showed up:", limit);
		for (int i = retireIdx; i < retireTab.size(); i++) begin
			$display("  retirement %0d of r%0d from pc %h", i, retireTab[i].rd, retireTab[i].pc);
		end
		for (int i = storeIdx; i < storeTab.size(); i++) begin
			$display("  store %0d to %h", i, storeTab[i].addr);
		end
	endtask

	initial begin
		int   cycles;
		int   limit;
		int   tail;
		logic timedOut;
		arstN     = 1'b0;
		imemData  = '0;
		retireIdx = 0;
		storeIdx  = 0;
		checks    = 0;
		errors    = 0;
		groupName = '{"alu forwarding", "store and load", "load use", "branches",
			"jal and jr", "register zero"};
		loadProgram();
		loadExpected();
		for (int g = 1; g <= NGROUPS; g++) begin
			groupLeft[g]   = 0;
			groupErrors[g] = 0;
		end
		foreach (retireTab[i]) begin
			groupLeft[retireTab[i].grp]++;
		end
		foreach (storeTab[i]) begin
			groupLeft[storeTab[i].grp]++;
		end
		limit = 8 * progWords.size() + 40;

		repeat (RESET_CYCLES) begin
			@(negedge clk);
			imemData = fetchWord(imemAddr);
		end
		arstN = 1'b1;

		// Keep running a few cycles past the last entry to catch extra retirements
		cycles = 0;
		tail   = 0;
		while (cycles < limit && tail < TAIL_CYCLES) begin
			@(negedge clk);
			compareCycle();
			imemData = fetchWord(imemAddr);
			cycles++;
			if (retireIdx >= retireTab.size() && storeIdx >= storeTab.size()) begin
				tail++;
			end
		end
		timedOut = tail < TAIL_CYCLES;
		if (timedOut) begin
			reportMissing(limit);
		end

		$display("%0d checks, %0d errors, %0d of %0d retirements, %0d of %0d stores",
			checks, errors, retireIdx, retireTab.size(), storeIdx, storeTab.size());
		if (errors == 0 && !timedOut) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: dv/mipsCore_properties.sv
`timescale 1ns/100ps
`include "mips_params.svh"
`default_nettype none

module mipsCore_properties (
	input logic                            clk,
	input logic                            arstN,
	input logic [`MIPS_XLEN-1:0]           imemAddr,
	input logic                            wbEn,
	input logic [$clog2(`MIPS_NREGS)-1:0] wbReg,
	input logic [`MIPS_XLEN-1:0]           wbData,
	input logic [`MIPS_XLEN-1:0]           wbPc,
	input logic                            memWrEn,
	input logic [`MIPS_XLEN-1:0]           memAddr,
	input logic [`MIPS_XLEN-1:0]           memWrData
);

	// Nothing retires or stores while reset is held
	quietInReset: assert property (@(posedge clk) !arstN |-> !wbEn && !memWrEn)
		else $error("retire or store strobe high during reset");

	// r0 writes are dropped before the trace
	noZeroRetire: assert property (@(posedge clk) disable iff (!arstN) wbEn |-> wbReg != '0)
		else $error("retirement reported for register zero");

	alignedFetch: assert property (@(posedge clk) imemAddr[1:0] == 2'b00)
		else $error("fetch address is not word aligned");

	knownPorts: assert property (@(posedge clk) disable iff (!arstN)
		!$isunknown({imemAddr, wbEn, wbReg, wbData, wbPc, memWrEn, memAddr, memWrData}))
		else $error("unknown value on a retirement or memory port");

endmodule

`default_nettype wire

// File: hdl/mipsCore.sv
`timescale 1ns/100ps
`include "mips_params.svh"
`default_nettype none

module mipsCore (
	input  logic                            clk,
	input  logic                            arstN,
	output logic [`MIPS_XLEN-1:0]           imemAddr,
	input  logic [`MIPS_XLEN-1:0]           imemData,
	output logic                            wbEn,
	output logic [$clog2(`MIPS_NREGS)-1:0] wbReg,
	output logic [`MIPS_XLEN-1:0]           wbData,
	output logic [`MIPS_XLEN-1:0]           wbPc,
	output logic                            memWrEn,
	output logic [`MIPS_XLEN-1:0]           memAddr,
	output logic [`MIPS_XLEN-1:0]           memWrData
);

	logic                  redirectEn;
	logic [`MIPS_XLEN-1:0] redirectPc;
	pipePkg::ctrlS         ctrlD;
	pipePkg::regIdxT       rsD;
	pipePkg::regIdxT       rtD;

	stageLink #(.payloadT(pipePkg::ifIdS))  ifIdLink ();
	stageLink #(.payloadT(pipePkg::idExS))  idExLink ();
	stageLink #(.payloadT(pipePkg::exMemS)) exMemLink ();
	stageLink #(.payloadT(pipePkg::memWbS)) memWbLink ();

	//////////////////////////////////////////////////////////////////////
	// Pipeline stages

	fetchStage uFetch (.clk(clk), .arstN(arstN), .imemAddr(imemAddr), .imemData(imemData),
		.redirectEn(redirectEn), .redirectPc(redirectPc), .toDecode(ifIdLink));

	decodeStage uDecode (.clk(clk), .arstN(arstN), .fromFetch(ifIdLink), .toExec(idExLink),
		.exTap(idExLink), .memTap(exMemLink), .wbTap(memWbLink), .redirectEn(redirectEn),
		.redirectPc(redirectPc), .ctrlD(ctrlD));

	executeStage uExecute (.clk(clk), .arstN(arstN), .fromDecode(idExLink), .toMem(exMemLink),
		.memTap(exMemLink), .wbTap(memWbLink));

	memoryStage uMemory (.clk(clk), .arstN(arstN), .fromExec(exMemLink), .toWb(memWbLink),
		.memWrEn(memWrEn), .memAddr(memAddr), .memWrData(memWrData));

	// Source registers of the instruction in decode
	assign rsD = ifIdLink.payload.instr[25:21];
	assign rtD = ifIdLink.payload.instr[20:16];

	hazardUnit uHazard (.ctrlD(ctrlD), .rsD(rsD), .rtD(rtD), .fetchLink(ifIdLink),
		.decodeLink(idExLink), .execLink(exMemLink), .memLink(memWbLink));

	// Retirement trace
	assign wbEn   = memWbLink.valid && memWbLink.payload.wrEn;
	assign wbReg  = memWbLink.payload.dest;
	assign wbData = memWbLink.payload.result;
	assign wbPc   = memWbLink.payload.pc;

endmodule

`default_nettype wire

// File: hdl/hazardUnit.sv
`timescale 1ns/100ps
`default_nettype none

module hazardUnit (
	input  pipePkg::ctrlS   ctrlD,
	input  pipePkg::regIdxT rsD,
	input  pipePkg::regIdxT rtD,
	stageLink.control       fetchLink,
	stageLink.control       decodeLink,
	stageLink.control       execLink,
	stageLink.control       memLink
);

	pipePkg::ctrlS exCtrl;
	pipePkg::ctrlS memCtrl;
	pipePkg::tnewT exTnew;
	pipePkg::tnewT memTnew;
	logic          exWr;
	logic          memWr;
	logic          stallRs;
	logic          stallRt;
	logic          stall;

	// Producers sitting in execute and in memory
	assign exCtrl  = decodeLink.payload.ctrl;
	assign memCtrl = execLink.payload.ctrl;
	assign exWr    = decodeLink.valid && exCtrl.regWrite && exCtrl.dest != '0;
	assign memWr   = execLink.valid && memCtrl.regWrite && memCtrl.dest != '0;

	assign exTnew  = exCtrl.memRead ? 2'd2 : (exCtrl.link ? 2'd0 : 2'd1);
	assign memTnew = memCtrl.memRead ? 2'd1 : 2'd0;

	assign stallRs = (exWr && exCtrl.dest == rsD && ctrlD.tuseRs < exTnew) ||
		(memWr && memCtrl.dest == rsD && ctrlD.tuseRs < memTnew);
	assign stallRt = (exWr && exCtrl.dest == rtD && ctrlD.tuseRt < exTnew) ||
		(memWr && memCtrl.dest == rtD && ctrlD.tuseRt < memTnew);
	assign stall   = stallRs || stallRt;

	// Hold fetch and decode, send a bubble into execute
	assign fetchLink.stall  = stall;
	assign fetchLink.flush  = 1'b0;
	assign decodeLink.stall = 1'b0;
	assign decodeLink.flush = stall;
	assign execLink.stall   = 1'b0;
	assign execLink.flush   = 1'b0;
	assign memLink.stall    = 1'b0;
	assign memLink.flush    = 1'b0;

endmodule

`default_nettype wire

// File: hdl/memoryStage.sv
`timescale 1ns/100ps
`include "mips_params.svh"
`default_nettype none

module memoryStage (
	input  logic                  clk,
	input  logic                  arstN,
	stageLink.consumer            fromExec,
	stageLink.producer            toWb,
	output logic                  memWrEn,
	output logic [`MIPS_XLEN-1:0] memAddr,
	output logic [`MIPS_XLEN-1:0] memWrData
);

	localparam int IDX_W = $clog2(`MIPS_DMEM_WORDS);

	pipePkg::exMemS        cur;
	pipePkg::wordT         loadData;
	pipePkg::wordT         result;
	logic [IDX_W-1:0]      wordIdx;
	logic [`MIPS_XLEN-1:0] dmem [`MIPS_DMEM_WORDS];

	assign cur     = fromExec.payload;
	assign wordIdx = cur.aluRes[IDX_W+1:2];

	// Store data can still be one stage behind, e.g. lw then sw of the same register
	assign memWrData = (toWb.valid && toWb.payload.wrEn && toWb.payload.dest == cur.rt) ?
		toWb.payload.result : cur.storeData;
	assign memWrEn   = fromExec.valid && cur.ctrl.memWrite;
	assign memAddr   = cur.aluRes;

	always_ff @(posedge clk) begin
		if (memWrEn) begin
			dmem[wordIdx] <= memWrData;
		end
	end

	assign loadData = dmem[wordIdx];
	assign result   = cur.ctrl.memRead ? loadData : cur.aluRes;

	// Memory to writeback register
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			toWb.payload <= '0;
			toWb.valid   <= 1'b0;
		end else if (toWb.flush) begin
			toWb.payload <= '0;
			toWb.valid   <= 1'b0;
		end else if (!toWb.stall) begin
			toWb.payload <= pipePkg::memWbS'{pc: cur.pc, dest: cur.ctrl.dest,
				wrEn: cur.ctrl.regWrite && cur.ctrl.dest != '0, result: result};
			toWb.valid   <= fromExec.valid;
		end
	end

endmodule

`default_nettype wire

// File: hdl/executeStage.sv
`timescale 1ns/100ps
`default_nettype none

module executeStage (
	input  logic       clk,
	input  logic       arstN,
	stageLink.consumer fromDecode,
	stageLink.producer toMem,
	stageLink.consumer memTap,
	stageLink.consumer wbTap
);

	pipePkg::idExS   cur;
	pipePkg::fwdSelE rsSel;
	pipePkg::fwdSelE rtSel;
	pipePkg::wordT   rsF;
	pipePkg::wordT   rtF;
	pipePkg::wordT   opB;
	pipePkg::wordT   aluRes;
	logic            memHit;
	logic            wbHit;

	function automatic pipePkg::wordT fwdVal(input pipePkg::fwdSelE sel,
			input pipePkg::wordT regVal, input pipePkg::wordT memVal, input pipePkg::wordT wbVal);
		case (sel)
			pipePkg::FWD_MEM: return memVal;
			pipePkg::FWD_WB:  return wbVal;
			default:          return regVal;
		endcase
	endfunction

	assign cur = fromDecode.payload;

	// A load in memory has no value yet; the hazard unit has stalled for it
	assign memHit = memTap.valid && memTap.payload.ctrl.regWrite && !memTap.payload.ctrl.memRead &&
		memTap.payload.ctrl.dest != '0;
	assign wbHit  = wbTap.valid && wbTap.payload.wrEn;

	assign rsSel = (memHit && memTap.payload.ctrl.dest == cur.rs) ? pipePkg::FWD_MEM :
		(wbHit && wbTap.payload.dest == cur.rs) ? pipePkg::FWD_WB : pipePkg::FWD_RF;
	assign rtSel = (memHit && memTap.payload.ctrl.dest == cur.rt) ? pipePkg::FWD_MEM :
		(wbHit && wbTap.payload.dest == cur.rt) ? pipePkg::FWD_WB : pipePkg::FWD_RF;

	assign rsF = fwdVal(rsSel, cur.rsVal, memTap.payload.aluRes, wbTap.payload.result);
	assign rtF = fwdVal(rtSel, cur.rtVal, memTap.payload.aluRes, wbTap.payload.result);
	assign opB = cur.ctrl.immSel ? cur.imm : rtF;

	always_comb begin
		case (cur.ctrl.aluOp)
			isaPkg::ALU_SUB: aluRes = rsF - opB;
			isaPkg::ALU_OR:  aluRes = rsF | opB;
			isaPkg::ALU_LUI: aluRes = {opB[15:0], 16'b0};
			default:         aluRes = rsF + opB;
		endcase
		// jal returns past its delay slot
		if (cur.ctrl.link) begin
			aluRes = cur.pc + 'd8;
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			toMem.payload <= '0;
			toMem.valid   <= 1'b0;
		end else if (toMem.flush) begin
			toMem.payload <= '0;
			toMem.valid   <= 1'b0;
		end else if (!toMem.stall) begin
			toMem.payload <= pipePkg::exMemS'{pc: cur.pc, ctrl: cur.ctrl, rt: cur.rt,
				aluRes: aluRes, storeData: rtF};
			toMem.valid   <= fromDecode.valid;
		end
	end

endmodule

`default_nettype wire

// File: hdl/decodeStage.sv
`timescale 1ns/100ps
`include "mips_params.svh"
`default_nettype none

module decodeStage (
	input  logic                  clk,
	input  logic                  arstN,
	stageLink.consumer            fromFetch,
	stageLink.producer            toExec,
	stageLink.consumer            exTap,
	stageLink.consumer            memTap,
	stageLink.consumer            wbTap,
	output logic                  redirectEn,
	output logic [`MIPS_XLEN-1:0] redirectPc,
	output pipePkg::ctrlS         ctrlD
);

	pipePkg::wordT   instr;
	pipePkg::wordT   pcSeq;
	pipePkg::wordT   immExt;
	pipePkg::wordT   rfRs;
	pipePkg::wordT   rfRt;
	pipePkg::wordT   rsVal;
	pipePkg::wordT   rtVal;
	pipePkg::regIdxT rs;
	pipePkg::regIdxT rt;
	pipePkg::tnewT   exTnew;
	pipePkg::tnewT   memTnew;
	pipePkg::fwdSelE rsSel;
	pipePkg::fwdSelE rtSel;
	logic            exHit;
	logic            memHit;
	logic            isBeq;
	logic            isJal;
	logic            isJr;
	logic            signExt;
	logic [`MIPS_XLEN-1:0] regs [`MIPS_NREGS];

	function automatic pipePkg::fwdSelE pickSrc(input pipePkg::regIdxT src, input logic exOk,
			input logic memOk);
		if (src == '0) begin
			return pipePkg::FWD_RF;
		end else if (exOk) begin
			return pipePkg::FWD_EX;
		end else if (memOk) begin
			return pipePkg::FWD_MEM;
		end
		return pipePkg::FWD_RF;
	endfunction

	assign instr  = fromFetch.payload.instr;
	assign rs     = instr[25:21];
	assign rt     = instr[20:16];
	assign pcSeq  = fromFetch.payload.pc + 'd4;
	assign immExt = signExt ? {{16{instr[15]}}, instr[15:0]} : {16'b0, instr[15:0]};

	//////////////////////////////////////////////////////////////////////
	// Control decode

	always_comb begin
		ctrlD        = '0;
		ctrlD.aluOp  = isaPkg::ALU_ADD;
		ctrlD.tuseRs = pipePkg::TUSE_NONE;
		ctrlD.tuseRt = pipePkg::TUSE_NONE;
		ctrlD.dest   = rt;
		isBeq        = 1'b0;
		isJal        = 1'b0;
		isJr         = 1'b0;
		signExt      = 1'b0;
		case (instr[31:26])
			isaPkg::OP_SPECIAL: begin
				// addu, subu, jr; anything else here is a nop
				ctrlD.dest     = instr[15:11];
				ctrlD.regWrite = (instr[5:0] == isaPkg::FN_ADDU) || (instr[5:0] == isaPkg::FN_SUBU);
				ctrlD.aluOp    = (instr[5:0] == isaPkg::FN_SUBU) ? isaPkg::ALU_SUB : isaPkg::ALU_ADD;
				isJr           = instr[5:0] == isaPkg::FN_JR;
				ctrlD.tuseRs   = isJr ? 2'd0 : 2'd1;
				ctrlD.tuseRt   = 2'd1;
			end
			isaPkg::OP_ORI, isaPkg::OP_LUI: begin
				ctrlD.regWrite = 1'b1;
				ctrlD.immSel   = 1'b1;
				ctrlD.aluOp    = (instr[31:26] == isaPkg::OP_ORI) ? isaPkg::ALU_OR : isaPkg::ALU_LUI;
				ctrlD.tuseRs   = 2'd1;
			end
			isaPkg::OP_LW, isaPkg::OP_SW: begin
				ctrlD.memRead  = instr[31:26] == isaPkg::OP_LW;
				ctrlD.memWrite = instr[31:26] == isaPkg::OP_SW;
				ctrlD.regWrite = instr[31:26] == isaPkg::OP_LW;
				ctrlD.immSel   = 1'b1;
				ctrlD.tuseRs   = 2'd1;
				// Store data is only needed in memory
				ctrlD.tuseRt   = ctrlD.memWrite ? 2'd2 : pipePkg::TUSE_NONE;
				signExt        = 1'b1;
			end
			isaPkg::OP_BEQ: begin
				isBeq        = 1'b1;
				signExt      = 1'b1;
				ctrlD.tuseRs = 2'd0;
				ctrlD.tuseRt = 2'd0;
			end
			isaPkg::OP_JAL: begin
				isJal          = 1'b1;
				ctrlD.regWrite = 1'b1;
				ctrlD.link     = 1'b1;
				ctrlD.dest     = isaPkg::REG_RA;
			end
			default: begin
			end
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Register file with write-through from writeback

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < `MIPS_NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wbTap.valid && wbTap.payload.wrEn) begin
			regs[wbTap.payload.dest] <= wbTap.payload.result;
		end
	end

	assign rfRs = (wbTap.valid && wbTap.payload.wrEn && wbTap.payload.dest == rs) ?
		wbTap.payload.result : regs[rs];
	assign rfRt = (wbTap.valid && wbTap.payload.wrEn && wbTap.payload.dest == rt) ?
		wbTap.payload.result : regs[rt];

	// Only a link in execute is ready; an ALU result is ready once in memory
	assign exTnew  = exTap.payload.ctrl.memRead ? 2'd2 : (exTap.payload.ctrl.link ? 2'd0 : 2'd1);
	assign memTnew = memTap.payload.ctrl.memRead ? 2'd1 : 2'd0;
	assign exHit   = exTap.valid && exTap.payload.ctrl.regWrite && exTnew == 2'd0;
	assign memHit  = memTap.valid && memTap.payload.ctrl.regWrite && memTnew == 2'd0;

	assign rsSel = pickSrc(rs, exHit && exTap.payload.ctrl.dest == rs,
		memHit && memTap.payload.ctrl.dest == rs);
	assign rtSel = pickSrc(rt, exHit && exTap.payload.ctrl.dest == rt,
		memHit && memTap.payload.ctrl.dest == rt);

	assign rsVal = (rsSel == pipePkg::FWD_EX) ? exTap.payload.pc + 'd8 :
		(rsSel == pipePkg::FWD_MEM) ? memTap.payload.aluRes : rfRs;
	assign rtVal = (rtSel == pipePkg::FWD_EX) ? exTap.payload.pc + 'd8 :
		(rtSel == pipePkg::FWD_MEM) ? memTap.payload.aluRes : rfRt;

	//////////////////////////////////////////////////////////////////////
	// Branch and jump resolution

	assign redirectEn = fromFetch.valid && ((isBeq && rsVal == rtVal) || isJal || isJr);
	assign redirectPc = isJr ? rsVal :
		isJal ? {pcSeq[31:28], instr[25:0], 2'b00} : pcSeq + {immExt[29:0], 2'b00};

	// Decode to execute register
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			toExec.payload <= '0;
			toExec.valid   <= 1'b0;
		end else if (toExec.flush) begin
			toExec.payload <= '0;
			toExec.valid   <= 1'b0;
		end else if (!toExec.stall) begin
			toExec.payload <= pipePkg::idExS'{pc: fromFetch.payload.pc, ctrl: ctrlD, rs: rs, rt: rt,
				rsVal: rsVal, rtVal: rtVal, imm: immExt};
			toExec.valid   <= fromFetch.valid;
		end
	end

endmodule

`default_nettype wire

// File: hdl/fetchStage.sv
`timescale 1ns/100ps
`include "mips_params.svh"
`default_nettype none

module fetchStage (
	input  logic                  clk,
	input  logic                  arstN,
	output logic [`MIPS_XLEN-1:0] imemAddr,
	input  logic [`MIPS_XLEN-1:0] imemData,
	input  logic                  redirectEn,
	input  logic [`MIPS_XLEN-1:0] redirectPc,
	stageLink.producer            toDecode
);

	logic [`MIPS_XLEN-1:0] pc;
	logic [`MIPS_XLEN-1:0] pcNext;

	assign imemAddr = pc;

	// Redirect arrives while the delay slot is being fetched
	assign pcNext = redirectEn ? redirectPc : pc + 'd4;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pc <= `MIPS_RESET_PC;
		end else if (!toDecode.stall) begin
			pc <= pcNext;
		end
	end

	// Fetch to decode register
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			toDecode.payload <= '0;
			toDecode.valid   <= 1'b0;
		end else if (toDecode.flush) begin
			toDecode.payload <= '0;
			toDecode.valid   <= 1'b0;
		end else if (!toDecode.stall) begin
			toDecode.payload <= pipePkg::ifIdS'{pc: pc, instr: imemData};
			toDecode.valid   <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: hdl/stageLink.sv
`timescale 1ns/100ps
`default_nettype none

interface stageLink #(
	parameter type payloadT = logic
) ();

	payloadT payload;
	logic    valid;

	// Hold and bubble requests from the hazard unit
	logic    stall;
	logic    flush;

	modport producer (output payload, output valid, input stall, input flush);
	modport consumer (input payload, input valid);
	modport control  (input payload, input valid, output stall, output flush);

endinterface

`default_nettype wire

// File: hdl/pipePkg.sv
`include "mips_params.svh"
`default_nettype none

package pipePkg;

	typedef logic [`MIPS_XLEN-1:0] wordT;
	typedef logic [$clog2(`MIPS_NREGS)-1:0] regIdxT;

	// Cycles until a result exists, also used for operand use times
	typedef logic [1:0] tnewT;

	// Use time of an operand that is never read
	localparam tnewT TUSE_NONE = 2'd3;

	typedef enum logic [1:0] {
		FWD_RF,
		FWD_EX,
		FWD_MEM,
		FWD_WB
	} fwdSelE;

	typedef struct packed {
		isaPkg::aluOpE aluOp;
		logic          immSel;
		logic          memWrite;
		logic          memRead;
		logic          regWrite;
		logic          link;
		regIdxT        dest;
		tnewT          tuseRs;
		tnewT          tuseRt;
	} ctrlS;

	typedef struct packed {
		wordT pc;
		wordT instr;
	} ifIdS;

	typedef struct packed {
		wordT   pc;
		ctrlS   ctrl;
		regIdxT rs;
		regIdxT rt;
		wordT   rsVal;
		wordT   rtVal;
		wordT   imm;
	} idExS;

	typedef struct packed {
		wordT   pc;
		ctrlS   ctrl;
		regIdxT rt;
		wordT   aluRes;
		wordT   storeData;
	} exMemS;

	typedef struct packed {
		wordT   pc;
		regIdxT dest;
		logic   wrEn;
		wordT   result;
	} memWbS;

endpackage

`default_nettype wire

// File: hdl/isaPkg.sv
`default_nettype none

package isaPkg;

	// Primary opcode, instr[31:26]
	typedef enum logic [5:0] {
		OP_SPECIAL = 6'h00,
		OP_JAL     = 6'h03,
		OP_BEQ     = 6'h04,
		OP_ORI     = 6'h0D,
		OP_LUI     = 6'h0F,
		OP_LW      = 6'h23,
		OP_SW      = 6'h2B
	} opcodeE;

	// Function field of the special opcode, instr[5:0]
	typedef enum logic [5:0] {
		FN_JR   = 6'h08,
		FN_ADDU = 6'h21,
		FN_SUBU = 6'h23
	} functE;

	typedef enum logic [1:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_OR,
		ALU_LUI
	} aluOpE;

	// Link register written by jal
	localparam logic [4:0] REG_RA = 5'd31;

endpackage

`default_nettype wire

// File: hdl/mips_params.svh
`ifndef MIPS_PARAMS_SVH
`define MIPS_PARAMS_SVH

// Data and address width
`define MIPS_XLEN 32

// First fetch address after reset
`define MIPS_RESET_PC 32'h0000_3000

// General purpose registers, r0 hardwired to zero
`define MIPS_NREGS 32

// Data memory depth in words
`define MIPS_DMEM_WORDS 1024

`endif
